// File: design/measure_pkg.sv
`default_nettype none

package measure_pkg;

	////////////////////////////////////////////////////////////////////////////
	// datapath widths
	////////////////////////////////////////////////////////////////////////////

	// one threshold dac code
	localparam int DAC_CODE_W = 16;
	// period counter, cycles of wb_clk_i
	localparam int STB_CNT_W = 28;
	// register index from wb_adr_i[4:2]
	localparam int REG_IDX_W = 3;

	typedef logic [DAC_CODE_W-1:0] dac_code_t;
	typedef logic [STB_CNT_W-1:0]  stb_cnt_t;
	typedef logic [REG_IDX_W-1:0]  reg_idx_t;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////

	// r: period[29:2] mux[1] rdy[0], w: mux[1] run[0]
	localparam reg_idx_t REG_STB = 3'd1;
	// r: dac2 rdy[1] dac1 rdy[0], w: code[15:0]
	localparam reg_idx_t REG_THRESHOLD = 3'd2;

	////////////////////////////////////////////////////////////////////////////
	// timing constants
	////////////////////////////////////////////////////////////////////////////

	// 8 zero bits then the code, msb first
	localparam int DAC_FRAME_W = 24;
	// wb_clk_i cycles per sclk half period
	localparam int DAC_CLK_DIV = 3;
	// sync high time before rdy returns
	localparam int DAC_WAIT_CYCLES = 3;
	// low samples needed before a rising edge is accepted
	localparam int ZERO_HOLD_CYCLES = 3;
	// code queue entries
	localparam int QUEUE_DEPTH = 4;

endpackage

`default_nettype wire

// File: design/stb_gen.sv
`default_nettype none

module stb_gen #(
	parameter int CNT_W = 28
) (
	input  wire logic             wb_clk_i,
	input  wire logic             wb_rst_i,
	input  wire logic             cmp1_i,
	input  wire logic             cmp2_i,
	input  wire logic             sel_i,
	input  wire logic             run_i,
	output logic                  rdy_o,
	output logic                  stb_o,
	output logic [CNT_W-1:0]      period_o
);
	import measure_pkg::*;

	localparam int LOW_W = $clog2(ZERO_HOLD_CYCLES + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ARM,
		ST_MEASURE,
		ST_GEN
	} stb_state_t;

	stb_state_t       state;
	logic             sig_mux;
	logic [1:0]       sig_sync;
	logic [LOW_W-1:0] low_cnt;
	logic             rise;
	logic [CNT_W-1:0] meas_cnt;
	logic [CNT_W-1:0] phase;

	// channel select before the synchronizer
	assign sig_mux = sel_i ? cmp2_i : cmp1_i;

	// two-flop synchronizer
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			sig_sync <= 2'b00;
		end else begin
			sig_sync <= {sig_sync[0], sig_mux};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// qualified rising edge
	////////////////////////////////////////////////////////////////////////////

	// consecutive low samples, saturating
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			low_cnt <= '0;
		end else if (sig_sync[1]) begin
			low_cnt <= '0;
		end else if (low_cnt != LOW_W'(ZERO_HOLD_CYCLES)) begin
			low_cnt <= low_cnt + 1'b1;
		end
	end

	// high after enough lows, short glitches never get here
	assign rise = sig_sync[1] && (low_cnt == LOW_W'(ZERO_HOLD_CYCLES));

	////////////////////////////////////////////////////////////////////////////
	// measurement and strobe fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state    <= ST_IDLE;
			rdy_o    <= 1'b0;
			stb_o    <= 1'b0;
			period_o <= '0;
			meas_cnt <= '0;
			phase    <= '0;
		end else begin
			stb_o <= 1'b0;
			if (run_i) begin
				// restart, strobes stop until a new period is known
				state <= ST_ARM;
				rdy_o <= 1'b0;
			end else begin
				case (state)
					ST_IDLE: begin
						rdy_o <= 1'b0;
					end
					ST_ARM: begin
						// first edge starts the count
						if (rise) begin
							meas_cnt <= CNT_W'(1);
							state    <= ST_MEASURE;
						end
					end
					ST_MEASURE: begin
						if (rise) begin
							// second edge closes the period
							period_o <= meas_cnt;
							rdy_o    <= 1'b1;
							phase    <= CNT_W'(1);
							state    <= ST_GEN;
						end else begin
							meas_cnt <= meas_cnt + 1'b1;
						end
					end
					ST_GEN: begin
						// free-running phase, one strobe per period
						if (phase == period_o) begin
							stb_o <= 1'b1;
							phase <= CNT_W'(1);
						end else begin
							phase <= phase + 1'b1;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: design/dac_code_queue.sv
`default_nettype none

module dac_code_queue #(
	parameter int DEPTH = 4
) (
	input  wire logic                   wb_clk_i,
	input  wire logic                   wb_rst_i,
	input  wire logic                   wr_i,
	input  wire measure_pkg::dac_code_t wdata_i,
	input  wire logic                   dac1_rdy_i,
	input  wire logic                   dac2_rdy_i,
	output logic                        full_o,
	output logic                        load_o,
	output measure_pkg::dac_code_t      code_o
);
	import measure_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dac_code_t  mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign full_o = (count == CNT_W'(DEPTH));
	assign push   = wr_i && !full_o;
	// both dacs idle so both get the same code at once
	assign pop    = (count != '0) && dac1_rdy_i && dac2_rdy_i;
	assign load_o = pop;
	// head entry, stable while load is high
	assign code_o = mem[rd_ptr];

	// storage
	always_ff @(posedge wb_clk_i) begin
		if (push) begin
			mem[wr_ptr] <= wdata_i;
		end
	end

	// pointers and fill level
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keep the level
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/dac_spi_master.sv
`default_nettype none

module dac_spi_master #(
	parameter int CLK_DIV = 3
) (
	input  wire logic                   wb_clk_i,
	input  wire logic                   wb_rst_i,
	input  wire logic                   load_i,
	input  wire measure_pkg::dac_code_t code_i,
	output logic                        rdy_o,
	output logic                        sync_o,
	output logic                        sclk_o,
	output logic                        sdi_o
);
	import measure_pkg::*;

	localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int BIT_W  = $clog2(DAC_FRAME_W + 1);
	localparam int WAIT_W = (DAC_WAIT_CYCLES > 1) ? $clog2(DAC_WAIT_CYCLES) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_WAIT
	} spi_state_t;

	spi_state_t             state;
	logic [DIV_W-1:0]       div_cnt;
	logic                   tick;
	logic [BIT_W-1:0]       bit_cnt;
	logic [WAIT_W-1:0]      wait_cnt;
	logic [DAC_FRAME_W-1:0] shreg;

	// one sclk half period elapsed
	assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));

	// frame shift register
	always_ff @(posedge wb_clk_i) begin
		if (state == ST_IDLE && load_i) begin
			// zero pad on top of the code
			shreg <= {{(DAC_FRAME_W - DAC_CODE_W){1'b0}}, code_i};
		end else if (state == ST_SHIFT && tick && !sclk_o) begin
			shreg <= {shreg[DAC_FRAME_W-2:0], 1'b0};
		end
	end

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state    <= ST_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			wait_cnt <= '0;
			rdy_o    <= 1'b1;
			sync_o   <= 1'b1;
			sclk_o   <= 1'b0;
			sdi_o    <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load_i) begin
						// sync falls, sclk stays low for a half period
						state   <= ST_SHIFT;
						rdy_o   <= 1'b0;
						sync_o  <= 1'b0;
						div_cnt <= '0;
						bit_cnt <= '0;
					end
				end
				ST_SHIFT: begin
					div_cnt <= tick ? '0 : div_cnt + 1'b1;
					if (tick) begin
						if (sclk_o) begin
							// falling edge, dac samples sdi here
							sclk_o <= 1'b0;
						end else if (bit_cnt == BIT_W'(DAC_FRAME_W)) begin
							// all bits out, close the frame
							sync_o   <= 1'b1;
							sdi_o    <= 1'b0;
							wait_cnt <= '0;
							state    <= ST_WAIT;
						end else begin
							// rising edge with the next bit, msb first
							sclk_o  <= 1'b1;
							sdi_o   <= shreg[DAC_FRAME_W-1];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				ST_WAIT: begin
					// sync held high before the next frame
					if (wait_cnt == WAIT_W'(DAC_WAIT_CYCLES - 1)) begin
						rdy_o <= 1'b1;
						state <= ST_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/measure_regs.sv
`default_nettype none

module measure_regs (
	input  wire logic                  wb_clk_i,
	input  wire logic                  wb_rst_i,
	input  wire logic [31:0]           wb_dat_i,
	input  wire logic [31:0]           wb_adr_i,
	input  wire logic                  wb_we_i,
	input  wire logic [3:0]            wb_sel_i,
	input  wire logic                  wb_cyc_i,
	input  wire logic                  wb_stb_i,
	input  wire logic                  queue_full_i,
	input  wire logic                  dac1_rdy_i,
	input  wire logic                  dac2_rdy_i,
	input  wire logic                  stb_rdy_i,
	input  wire measure_pkg::stb_cnt_t stb_period_i,
	output logic [31:0]                wb_dat_o,
	output logic                       wb_ack_o,
	output logic                       stb_run_o,
	output logic                       stb_sel_o,
	output logic                       code_wr_o,
	output measure_pkg::dac_code_t     code_wdata_o
);
	import measure_pkg::*;

	reg_idx_t    reg_idx;
	logic        bus_req;
	logic        thr_stall;
	logic        accept;
	logic [31:0] cur_val;
	logic [31:0] w_data;
	logic [31:0] rd_data;

	////////////////////////////////////////////////////////////////////////////
	// request decode
	////////////////////////////////////////////////////////////////////////////

	assign reg_idx = wb_adr_i[4:2];
	// new request only while ack is low
	assign bus_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
	// threshold write into a full queue waits for room
	assign thr_stall = wb_we_i && (reg_idx == REG_THRESHOLD) && queue_full_i;
	assign accept = bus_req && !thr_stall;

	// current value per register, source for unselected lanes
	always_comb begin
		case (reg_idx)
			REG_STB: begin
				// run is a pulse, reads back as 0
				cur_val = {30'd0, stb_sel_o, 1'b0};
			end
			REG_THRESHOLD: begin
				cur_val = {{(32 - DAC_CODE_W){1'b0}}, code_wdata_o};
			end
			default: begin
				cur_val = '0;
			end
		endcase
	end

	// byte lane merge
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			w_data[8*i +: 8] = wb_sel_i[i] ? wb_dat_i[8*i +: 8] : cur_val[8*i +: 8];
		end
	end

	// read mux
	always_comb begin
		case (reg_idx)
			REG_STB: begin
				rd_data = {{(30 - STB_CNT_W){1'b0}}, stb_period_i, stb_sel_o, stb_rdy_i};
			end
			REG_THRESHOLD: begin
				rd_data = {30'd0, dac2_rdy_i, dac1_rdy_i};
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// registers, ack and pulses
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wb_ack_o     <= 1'b0;
			stb_run_o    <= 1'b0;
			stb_sel_o    <= 1'b0;
			code_wr_o    <= 1'b0;
			code_wdata_o <= '0;
		end else begin
			// single cycle ack and pulses
			wb_ack_o  <= accept;
			stb_run_o <= 1'b0;
			code_wr_o <= 1'b0;
			if (accept && wb_we_i) begin
				case (reg_idx)
					REG_STB: begin
						stb_run_o <= w_data[0];
						stb_sel_o <= w_data[1];
					end
					REG_THRESHOLD: begin
						// push into the code queue
						code_wdata_o <= w_data[DAC_CODE_W-1:0];
						code_wr_o    <= 1'b1;
					end
					default: begin
						stb_run_o <= 1'b0;
					end
				endcase
			end
		end
	end

	// read data, valid with ack
	always_ff @(posedge wb_clk_i) begin
		if (accept && !wb_we_i) begin
			wb_dat_o <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: design/measure_unit.sv
`default_nettype none

module measure_unit (
	input  wire logic        wb_clk_i,
	input  wire logic        wb_rst_i,
	input  wire logic [31:0] wb_dat_i,
	input  wire logic [31:0] wb_adr_i,
	input  wire logic        wb_we_i,
	input  wire logic [3:0]  wb_sel_i,
	input  wire logic        wb_cyc_i,
	input  wire logic        wb_stb_i,
	output logic [31:0]      wb_dat_o,
	output logic             wb_ack_o,
	input  wire logic        cmp1_out_i,
	input  wire logic        cmp2_out_i,
	output logic             dac1_sync_o,
	output logic             dac1_sclk_o,
	output logic             dac1_sdi_o,
	output logic             dac2_sync_o,
	output logic             dac2_sclk_o,
	output logic             dac2_sdi_o,
	output logic             delay1_stb_o,
	output logic             delay2_stb_o
);
	import measure_pkg::*;

	logic      stb_run;
	logic      stb_sel;
	logic      stb_rdy;
	logic      stb;
	stb_cnt_t  stb_period;
	logic      code_wr;
	dac_code_t code_wdata;
	logic      queue_full;
	logic      dac_load;
	dac_code_t dac_code;
	logic      dac1_rdy;
	logic      dac2_rdy;

	// same strobe to both delay lines
	assign delay1_stb_o = stb;
	assign delay2_stb_o = stb;

	////////////////////////////////////////////////////////////////////////////
	// bus side
	////////////////////////////////////////////////////////////////////////////

	measure_regs i_regs (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.wb_dat_i     (wb_dat_i),
		.wb_adr_i     (wb_adr_i),
		.wb_we_i      (wb_we_i),
		.wb_sel_i     (wb_sel_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.queue_full_i (queue_full),
		.dac1_rdy_i   (dac1_rdy),
		.dac2_rdy_i   (dac2_rdy),
		.stb_rdy_i    (stb_rdy),
		.stb_period_i (stb_period),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.stb_run_o    (stb_run),
		.stb_sel_o    (stb_sel),
		.code_wr_o    (code_wr),
		.code_wdata_o (code_wdata)
	);

	// comparator period and strobes
	stb_gen #(
		.CNT_W (STB_CNT_W)
	) i_stb_gen (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.cmp1_i   (cmp1_out_i),
		.cmp2_i   (cmp2_out_i),
		.sel_i    (stb_sel),
		.run_i    (stb_run),
		.rdy_o    (stb_rdy),
		.stb_o    (stb),
		.period_o (stb_period)
	);

	////////////////////////////////////////////////////////////////////////////
	// threshold path to the dacs
	////////////////////////////////////////////////////////////////////////////

	dac_code_queue #(
		.DEPTH (QUEUE_DEPTH)
	) i_queue (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.wr_i       (code_wr),
		.wdata_i    (code_wdata),
		.dac1_rdy_i (dac1_rdy),
		.dac2_rdy_i (dac2_rdy),
		.full_o     (queue_full),
		.load_o     (dac_load),
		.code_o     (dac_code)
	);

	dac_spi_master #(
		.CLK_DIV (DAC_CLK_DIV)
	) i_dac1_spi (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.load_i   (dac_load),
		.code_i   (dac_code),
		.rdy_o    (dac1_rdy),
		.sync_o   (dac1_sync_o),
		.sclk_o   (dac1_sclk_o),
		.sdi_o    (dac1_sdi_o)
	);

	dac_spi_master #(
		.CLK_DIV (DAC_CLK_DIV)
	) i_dac2_spi (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.load_i   (dac_load),
		.code_i   (dac_code),
		.rdy_o    (dac2_rdy),
		.sync_o   (dac2_sync_o),
		.sclk_o   (dac2_sclk_o),
		.sdi_o    (dac2_sdi_o)
	);

endmodule

`default_nettype wire

// File: testbench/tb_measure_unit.sv
`default_nettype none

module tb_measure_unit;
	timeunit 1ns;
	timeprecision 1ps;

	import measure_pkg::*;

	// per-wait limits in wb_clk_i cycles
	localparam int ACK_TIMEOUT   = 1000;
	localparam int FRAME_TIMEOUT = 5000;
	localparam int POLL_LIMIT    = 200;
	localparam int STB_TIMEOUT   = 400;

	logic        wb_clk_i;
	logic        wb_rst_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_adr_i;
	logic        wb_we_i;
	logic [3:0]  wb_sel_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic        cmp1_out_i;
	logic        cmp2_out_i;
	logic        dac1_sync_o;
	logic        dac1_sclk_o;
	logic        dac1_sdi_o;
	logic        dac2_sync_o;
	logic        dac2_sclk_o;
	logic        dac2_sdi_o;
	logic        delay1_stb_o;
	logic        delay2_stb_o;

	// spi receive side
	logic [DAC_FRAME_W-1:0] dac1_shift;
	logic [DAC_FRAME_W-1:0] dac2_shift;
	int                     dac1_bits = 0;
	int                     dac2_bits = 0;
	logic [DAC_FRAME_W-1:0] dac1_frames[$];
	logic [DAC_FRAME_W-1:0] dac2_frames[$];

	// comparator wave control
	logic        wave_on   = 1'b0;
	logic        wave_busy = 1'b0;
	int          run_pulses = 0;
	logic [31:0] lcg_state = 32'h03cc_51cd;

	measure_unit i_dut (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.wb_dat_i     (wb_dat_i),
		.wb_adr_i     (wb_adr_i),
		.wb_we_i      (wb_we_i),
		.wb_sel_i     (wb_sel_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.cmp1_out_i   (cmp1_out_i),
		.cmp2_out_i   (cmp2_out_i),
		.dac1_sync_o  (dac1_sync_o),
		.dac1_sclk_o  (dac1_sclk_o),
		.dac1_sdi_o   (dac1_sdi_o),
		.dac2_sync_o  (dac2_sync_o),
		.dac2_sclk_o  (dac2_sclk_o),
		.dac2_sdi_o   (dac2_sdi_o),
		.delay1_stb_o (delay1_stb_o),
		.delay2_stb_o (delay2_stb_o)
	);

	// 20 ns period
	initial begin
		wb_clk_i = 1'b0;
		forever begin
			#10 wb_clk_i = ~wb_clk_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// lcg with the numerical recipes constants
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] reg_addr(input reg_idx_t idx);
		return {27'd0, idx, 2'b00};
	endfunction

	// run pulses seen by stb_gen
	always @(negedge wb_clk_i) begin
		if (i_dut.stb_run === 1'b1) begin
			run_pulses++;
		end
	end

	// dac1 model samples sdi on sclk fall and closes the frame on sync rise
	always @(negedge dac1_sclk_o or posedge dac1_sync_o) begin
		if (dac1_sync_o === 1'b1) begin
			if (dac1_bits != 0) begin
				check_value("dac1 frame bits", dac1_bits, DAC_FRAME_W);
				dac1_frames.push_back(dac1_shift);
				dac1_bits = 0;
			end
		end else begin
			dac1_shift = {dac1_shift[DAC_FRAME_W-2:0], dac1_sdi_o};
			dac1_bits++;
		end
	end

	// dac2 model
	always @(negedge dac2_sclk_o or posedge dac2_sync_o) begin
		if (dac2_sync_o === 1'b1) begin
			if (dac2_bits != 0) begin
				check_value("dac2 frame bits", dac2_bits, DAC_FRAME_W);
				dac2_frames.push_back(dac2_shift);
				dac2_bits = 0;
			end
		end else begin
			dac2_shift = {dac2_shift[DAC_FRAME_W-2:0], dac2_sdi_o};
			dac2_bits++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus tasks
	////////////////////////////////////////////////////////////////////////////

	// ack sampled at the falling edge and stb dropped on the next rise
	task automatic wait_ack(input string what);
		int n;
		n = 0;
		@(negedge wb_clk_i);
		while (wb_ack_o !== 1'b1) begin
			if (n == ACK_TIMEOUT) begin
				fail_run($sformatf("no wishbone ack on %s", what));
			end else begin
				n++;
				@(negedge wb_clk_i);
			end
		end
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		@(posedge wb_clk_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= 1'b1;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		wait_ack("write");
		@(posedge wb_clk_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
		@(posedge wb_clk_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= 1'b0;
		wb_adr_i <= adr;
		wb_sel_i <= 4'hf;
		wait_ack("read");
		// data valid together with ack
		dat = wb_dat_o;
		@(posedge wb_clk_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
	endtask

	// poll a register until the masked bits match
	task automatic poll_reg(input reg_idx_t idx, input logic [31:0] mask,
		input logic [31:0] want, output logic [31:0] val);
		int n;
		n = 0;
		wb_read(reg_addr(idx), val);
		while ((val & mask) !== want) begin
			if (n == POLL_LIMIT) begin
				fail_run($sformatf("register %0d never reached the expected state", idx));
			end else begin
				n++;
				wb_read(reg_addr(idx), val);
			end
		end
	endtask

	task automatic wait_frames(input int n);
		int t;
		t = 0;
		while (dac1_frames.size() < n || dac2_frames.size() < n) begin
			if (t == FRAME_TIMEOUT) begin
				fail_run("timeout waiting for dac frames");
			end else begin
				t++;
				@(negedge wb_clk_i);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// comparator model
	////////////////////////////////////////////////////////////////////////////

	task automatic set_cmp(input logic on_cmp2, input logic level);
		if (on_cmp2) begin
			cmp2_out_i <= level;
		end else begin
			cmp1_out_i <= level;
		end
	endtask

	// square wave with an optional one cycle low glitch mid high phase
	task automatic drive_wave(input logic on_cmp2, input int high_cyc, input int low_cyc,
		input logic glitch);
		wave_busy = 1'b1;
		while (wave_on) begin
			for (int i = 0; i < high_cyc; i++) begin
				@(posedge wb_clk_i);
				set_cmp(on_cmp2, !(glitch && i == high_cyc / 2));
			end
			for (int i = 0; i < low_cyc; i++) begin
				@(posedge wb_clk_i);
				set_cmp(on_cmp2, 1'b0);
			end
		end
		wave_busy = 1'b0;
	endtask

	task automatic stop_wave();
		int n;
		n = 0;
		wave_on = 1'b0;
		while (wave_busy) begin
			if (n == POLL_LIMIT) begin
				fail_run("comparator wave did not stop");
			end else begin
				n++;
				@(negedge wb_clk_i);
			end
		end
		@(posedge wb_clk_i);
		cmp1_out_i <= 1'b0;
		cmp2_out_i <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_values();
		logic [31:0] rd;
		wb_read(reg_addr(REG_STB), rd);
		check_value("REG_STB", rd, 32'h0);
		wb_read(reg_addr(REG_THRESHOLD), rd);
		check_value("REG_THRESHOLD", rd, 32'h3);
		check_value("dac1_sync_o", dac1_sync_o, 1'b1);
		check_value("dac2_sync_o", dac2_sync_o, 1'b1);
		check_value("dac1_sclk_o", dac1_sclk_o, 1'b0);
		check_value("dac2_sclk_o", dac2_sclk_o, 1'b0);
		check_value("dac1_sdi_o", dac1_sdi_o, 1'b0);
		check_value("dac2_sdi_o", dac2_sdi_o, 1'b0);
		check_value("delay1_stb_o", delay1_stb_o, 1'b0);
		check_value("delay2_stb_o", delay2_stb_o, 1'b0);
	endtask

	task automatic test_single_write();
		logic [31:0] rd;
		logic [15:0] code;
		code = next_random() >> 16;
		wb_write(reg_addr(REG_THRESHOLD), {16'h0, code}, 4'hf);
		wait_frames(1);
		// 8 zero bits then the code
		check_value("dac1 frame", dac1_frames.pop_front(), {8'h00, code});
		check_value("dac2 frame", dac2_frames.pop_front(), {8'h00, code});
		poll_reg(REG_THRESHOLD, 32'hffff_ffff, 32'h3, rd);
	endtask

	// six writes against four queue entries
	task automatic test_back_pressure();
		logic [15:0] codes[$];
		logic [15:0] c;
		for (int i = 0; i < 6; i++) begin
			c = next_random() >> 16;
			codes.push_back(c);
			wb_write(reg_addr(REG_THRESHOLD), {16'h0, c}, 4'hf);
		end
		wait_frames(6);
		check_value("dac1 frame count", dac1_frames.size(), 6);
		check_value("dac2 frame count", dac2_frames.size(), 6);
		foreach (codes[i]) begin
			check_value($sformatf("dac1 frame %0d", i), dac1_frames[i], {8'h00, codes[i]});
			check_value($sformatf("dac2 frame %0d", i), dac2_frames[i], {8'h00, codes[i]});
		end
		dac1_frames.delete();
		dac2_frames.delete();
	endtask

	task automatic test_byte_selects();
		logic [31:0] rd;
		int run_base;
		run_base = run_pulses;
		// only byte 0 sets mux and pulses run
		wb_write(reg_addr(REG_STB), 32'h0000_0003, 4'b0001);
		check_value("run pulses", run_pulses, run_base + 1);
		// byte 0 masked off keeps mux and gives no run
		wb_write(reg_addr(REG_STB), 32'h0000_0000, 4'b1110);
		check_value("run pulses", run_pulses, run_base + 1);
		wb_read(reg_addr(REG_STB), rd);
		check_value("REG_STB", rd, 32'h0000_0002);
	endtask

	task automatic test_period(input logic glitch, input logic check_gaps);
		logic [31:0] rd;
		logic [31:0] exp;
		int stb_at[$];
		int cyc;
		exp = {2'b00, 28'd50, 1'b1, 1'b1};
		// mux is 1 so the wave goes to cmp2 and cmp1 stays low
		wave_on = 1'b1;
		fork
			drive_wave(1'b1, 20, 30, glitch);
		join_none
		wb_write(reg_addr(REG_STB), 32'h0000_0003, 4'hf);
		poll_reg(REG_STB, 32'h1, 32'h1, rd);
		check_value("REG_STB", rd, exp);
		cyc = 0;
		while (check_gaps && stb_at.size() < 4) begin
			@(negedge wb_clk_i);
			cyc++;
			if (cyc > STB_TIMEOUT) begin
				fail_run("delay strobes stopped");
			end else if (delay1_stb_o === 1'b1) begin
				check_value("delay2_stb_o", delay2_stb_o, 1'b1);
				stb_at.push_back(cyc);
			end
		end
		for (int i = 1; i < stb_at.size(); i++) begin
			check_value("strobe gap", stb_at[i] - stb_at[i-1], 50);
		end
		stop_wave();
	endtask

	initial begin
		wb_rst_i   = 1'b1;
		wb_dat_i   = '0;
		wb_adr_i   = '0;
		wb_we_i    = 1'b0;
		wb_sel_i   = '0;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		cmp1_out_i = 1'b0;
		cmp2_out_i = 1'b0;
		repeat (8) @(posedge wb_clk_i);
		wb_rst_i <= 1'b0;
		test_reset_values();
		test_single_write();
		test_back_pressure();
		test_byte_selects();
		test_period(1'b0, 1'b1);
		test_period(1'b1, 1'b0);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: measure_unit.f
design/measure_pkg.sv
design/stb_gen.sv
design/dac_code_queue.sv
design/dac_spi_master.sv
design/measure_regs.sv
design/measure_unit.sv
testbench/tb_measure_unit.sv

// File: Makefile
TOP := tb_measure_unit
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): measure_unit.f design/*.sv testbench/*.sv
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) --Mdir $(OBJ) -f measure_unit.f

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module measure_unit -f measure_unit.f

clean:
	rm -rf $(OBJ) sim.log
